// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator and run, exit status follows the simulation result
verilator --binary --timing --assert -j 0 \
    --top-module tb_vic_core \
    -f verilog.f \
    -o sim_vic \
    && ./obj_dir/sim_vic \
    || { echo "simulation failed"; exit 1; }

// ==== src/badline_arbiter.sv ====
`timescale 1ns/1ps

module badline_arbiter import vic_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  phase_t      phase_i,
    input  raster_pos_t pos_i,
    input  vic_ctrl_t   ctrl_i,
    output logic        ba_o,
    output logic        aec_o
);

    logic                 allow_bad_lines;
    logic                 allow_next;
    logic                 badline;
    logic                 badline_next;
    logic                 in_char_window;
    logic                 eval_tick;
    logic                 high_start;
    logic [AEC_HOLDOFF:0] ba_low_hist;

    // ------------------------------
    // badline condition
    // ------------------------------

    // line number settles early in the low phase
    assign eval_tick = !phase_i.phi && (phase_i.phase_idx == 4'd1);

    // den only counts while on line 48, window closes at 248
    always_comb begin
        allow_next = allow_bad_lines;
        if (pos_i.raster_line == BADLINE_LAST_LINE + 9'd1) begin
            allow_next = 1'b0;
        end else if (ctrl_i.den && pos_i.raster_line == DEN_CHECK_LINE) begin
            allow_next = 1'b1;
        end
    end

    assign badline_next = allow_next &&
                          (pos_i.raster_line >= BADLINE_FIRST_LINE) &&
                          (pos_i.raster_line <= BADLINE_LAST_LINE) &&
                          (pos_i.raster_line[2:0] == ctrl_i.yscroll);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline         <= 1'b0;
        end else if (eval_tick) begin
            allow_bad_lines <= allow_next;
            badline         <= badline_next;
        end
    end

    // ------------------------------
    // ba and aec
    // ------------------------------

    assign in_char_window = (pos_i.cycle_num >= CHAR_BA_FIRST_CYCLE) &&
                            (pos_i.cycle_num <= CHAR_BA_LAST_CYCLE);

    // ba is active low
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o <= 1'b1;
        end else begin
            ba_o <= !(badline && in_char_window);
        end
    end

    // the edge that opens the next high phase
    assign high_start = !phase_i.phi && (phase_i.phase_idx == 4'(TICKS_PER_HALF - 1));

    // bit n set when ba was low at the last n+1 high phase starts
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_low_hist <= '0;
        end else if (high_start) begin
            ba_low_hist <= {ba_low_hist[AEC_HOLDOFF-1:0], 1'b1} & {(AEC_HOLDOFF + 1){!ba_o}};
        end
    end

    // cpu keeps the bus until the holdoff has run out
    assign aec_o = phase_i.phi && !ba_low_hist[AEC_HOLDOFF];

    // bus never goes to the cpu in the low phase
    aec_low_in_phi_low_a: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        !phase_i.phi |-> !aec_o
    );

endmodule

// ==== src/phi_phase_gen.sv ====
`timescale 1ns/1ps

module phi_phase_gen import vic_pkg::*; (
    input  logic   clk_dot4x,
    input  logic   rst,
    output phase_t phase_o
);

    // one full phi period is two half phases
    localparam int CNT_W = $clog2(2 * TICKS_PER_HALF);

    // top bit is phi, the rest is the index inside the half phase
    logic [CNT_W-1:0] phase_cnt;

    // ------------------------------
    // free running phase counter
    // ------------------------------

    // starts at index 0 of a low phase
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_cnt <= '0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    // ------------------------------
    // decode
    // ------------------------------

    always_comb begin
        phase_o.phi       = phase_cnt[CNT_W-1];
        phase_o.phase_idx = phase_cnt[CNT_W-2:0];
        // four ticks per pixel, last one moves the pixel counter
        phase_o.dot_tick  = &phase_cnt[1:0];
    end

    // ------------------------------
    // checks
    // ------------------------------

    // phi may only flip as the half phase index wraps
    phi_edge_on_wrap_a: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        $changed(phase_o.phi) |->
            ($past(phase_o.phase_idx) == 4'(TICKS_PER_HALF - 1)) &&
            (phase_o.phase_idx == 4'd0)
    );

endmodule

// ==== src/raster_counter.sv ====
`timescale 1ns/1ps

module raster_counter import vic_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  chip_e       chip_i,
    input  phase_t      phase_i,
    output raster_pos_t pos_o
);

    logic [9:0] x_max;
    logic [8:0] y_max;
    logic [9:0] raster_x;
    logic [8:0] raster_line;
    logic [8:0] raster_line_d;

    // limits for the selected chip
    assign x_max = RASTER_X_MAX[chip_i];
    assign y_max = RASTER_Y_MAX[chip_i];

    // ------------------------------
    // pixel and line counters
    // ------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x      <= '0;
            raster_line   <= '0;
            raster_line_d <= '0;
        end else begin
            // irq compare works on the line one tick late
            raster_line_d <= raster_line;
            if (phase_i.dot_tick) begin
                if (raster_x >= x_max) begin
                    raster_x <= '0;
                    // end of line, step or wrap the line
                    if (raster_line >= y_max) begin
                        raster_line <= '0;
                    end else begin
                        raster_line <= raster_line + 9'd1;
                    end
                end else begin
                    raster_x <= raster_x + 10'd1;
                end
            end
        end
    end

    // eight pixels per phi cycle
    always_comb begin
        pos_o.raster_x      = raster_x;
        pos_o.cycle_num     = raster_x[9:3];
        pos_o.raster_line   = raster_line;
        pos_o.raster_line_d = raster_line_d;
    end

    // x position stays inside the line of the chip in use
    raster_x_in_range_a: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        raster_x <= x_max
    );

endmodule

// ==== src/vic_core.sv ====
`timescale 1ns/1ps

module vic_core import vic_pkg::*; (
    input  logic       clk_dot4x,
    input  logic       rst,
    input  chip_e      chip_i,
    input  logic [5:0] adi_i,
    input  logic [7:0] dbi_i,
    input  logic       ce_i,
    input  logic       rw_i,
    output logic [7:0] dbo_o,
    output logic       irq_o,
    output logic       ba_o,
    output logic       aec_o,
    output logic       clk_phi_o,
    output logic       vic_write_db_o
);

    phase_t      phase;
    raster_pos_t pos;
    vic_ctrl_t   ctrl;

    // ------------------------------
    // sequencing
    // ------------------------------

    phi_phase_gen phi_phase_gen_i (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase)
    );

    assign clk_phi_o = phase.phi;

    raster_counter raster_counter_i (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip_i),
        .phase_i   (phase),
        .pos_o     (pos)
    );

    // ------------------------------
    // bus arbitration and cpu side
    // ------------------------------

    badline_arbiter badline_arbiter_i (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .pos_i     (pos),
        .ctrl_i    (ctrl),
        .ba_o      (ba_o),
        .aec_o     (aec_o)
    );

    vic_regs vic_regs_i (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .phase_i        (phase),
        .pos_i          (pos),
        .adi_i          (adi_i),
        .dbi_i          (dbi_i),
        .ce_i           (ce_i),
        .rw_i           (rw_i),
        .dbo_o          (dbo_o),
        .vic_write_db_o (vic_write_db_o),
        .irq_o          (irq_o),
        .ctrl_o         (ctrl)
    );

endmodule

// ==== src/vic_pkg.sv ====
package vic_pkg;

    // ------------------------------
    // chip and register encodings
    // ------------------------------

    // supported chip models
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6567R56A = 2'd1,
        CHIP_6569     = 2'd2
    } chip_e;

    // register offsets seen on adi
    typedef enum logic [5:0] {
        REG_CTRL1     = 6'h11,
        REG_RASTER    = 6'h12,
        REG_IRQ_LATCH = 6'h19,
        REG_IRQ_EN    = 6'h1A
    } reg_addr_e;

    // ------------------------------
    // timing constants
    // ------------------------------

    // dot4x ticks in one phi half phase
    localparam int TICKS_PER_HALF = 16;

    // phase index where cpu write data is stable
    localparam logic [3:0] DATA_DAV = 4'd11;
    // low phase index for the raster compare
    localparam logic [3:0] IRQ_CHECK_TICK = 4'd8;

    localparam logic [8:0] BADLINE_FIRST_LINE = 9'd48;
    localparam logic [8:0] BADLINE_LAST_LINE  = 9'd247;
    localparam logic [8:0] DEN_CHECK_LINE     = 9'd48;

    // cycles with ba low on a badline
    localparam logic [6:0] CHAR_BA_FIRST_CYCLE = 7'd12;
    localparam logic [6:0] CHAR_BA_LAST_CYCLE  = 7'd54;

    // high phases of ba low before aec is taken
    localparam int AEC_HOLDOFF = 3;

    // per chip limits, index is the chip code
    // code 3 is not a chip and mirrors the 6569
    localparam logic [3:0][9:0] RASTER_X_MAX = {10'd503, 10'd503, 10'd511, 10'd519};
    localparam logic [3:0][8:0] RASTER_Y_MAX = {9'd311, 9'd311, 9'd261, 9'd262};

    // ------------------------------
    // shared bundles
    // ------------------------------

    typedef struct packed {
        logic       phi;
        logic [3:0] phase_idx;
        logic       dot_tick;
    } phase_t;

    typedef struct packed {
        logic [9:0] raster_x;
        logic [6:0] cycle_num;
        logic [8:0] raster_line;
        logic [8:0] raster_line_d;
    } raster_pos_t;

    typedef struct packed {
        logic       den;
        logic [2:0] yscroll;
        logic [8:0] raster_compare;
        logic       erst;
    } vic_ctrl_t;

endpackage

// ==== src/vic_regs.sv ====
`timescale 1ns/1ps

module vic_regs import vic_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  phase_t      phase_i,
    input  raster_pos_t pos_i,
    input  logic [5:0]  adi_i,
    input  logic [7:0]  dbi_i,
    input  logic        ce_i,
    input  logic        rw_i,
    output logic [7:0]  dbo_o,
    output logic        vic_write_db_o,
    output logic        irq_o,
    output vic_ctrl_t   ctrl_o
);

    reg_addr_e addr;
    vic_ctrl_t ctrl_q;
    logic      wr_stb;
    logic      irq_check;
    logic      irst;
    logic      irq_fired;

    assign addr = reg_addr_e'(adi_i);

    // cpu write strobe on the tick where data is valid mid high phase
    assign wr_stb = phase_i.phi && (phase_i.phase_idx == DATA_DAV) && !ce_i && !rw_i;

    // raster compare point in the low phase
    assign irq_check = !phase_i.phi && (phase_i.phase_idx == IRQ_CHECK_TICK);

    // chip drives the data bus while the cpu reads it
    assign vic_write_db_o = rw_i && !ce_i;

    // ------------------------------
    // register writes
    // ------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl_q <= '0;
        end else if (wr_stb) begin
            case (addr)
                REG_CTRL1: begin
                    // bit 7 is the compare msb
                    ctrl_q.raster_compare[8] <= dbi_i[7];
                    ctrl_q.den               <= dbi_i[4];
                    ctrl_q.yscroll           <= dbi_i[2:0];
                end
                REG_RASTER: begin
                    ctrl_q.raster_compare[7:0] <= dbi_i;
                end
                REG_IRQ_EN: begin
                    ctrl_q.erst <= dbi_i[0];
                end
                default: begin
                    ctrl_q <= ctrl_q;
                end
            endcase
        end
    end

    assign ctrl_o = ctrl_q;

    // ------------------------------
    // raster interrupt
    // ------------------------------

    // latch fires once per matching line even with erst off
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst      <= 1'b0;
            irq_fired <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            if (pos_i.raster_line_d != ctrl_q.raster_compare) begin
                irq_fired <= 1'b0;
            end else if (irq_check && !irq_fired) begin
                irst      <= 1'b1;
                irq_fired <= 1'b1;
            end
            // writing a one acknowledges the latch
            if (wr_stb && addr == REG_IRQ_LATCH && dbi_i[0]) begin
                irst <= 1'b0;
            end
            irq_o <= irst && ctrl_q.erst;
        end
    end

    // ------------------------------
    // read data
    // ------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dbo_o <= '0;
        end else begin
            case (addr)
                REG_CTRL1:     dbo_o <= {pos_i.raster_line[8], 2'b00, ctrl_q.den, 1'b0,
                                         ctrl_q.yscroll};
                REG_RASTER:    dbo_o <= pos_i.raster_line[7:0];
                REG_IRQ_LATCH: dbo_o <= {irq_o, 6'h3F, irst};
                REG_IRQ_EN:    dbo_o <= {7'h7F, ctrl_q.erst};
                default:       dbo_o <= 8'hFF;
            endcase
        end
    end

endmodule

// ==== verif/tb_vic_core.sv ====
`timescale 1ns/1ps

module tb_vic_core import vic_pkg::*; ();

    // ------------------------------
    // run limits
    // ------------------------------

    localparam int PHI_TICKS = 2 * TICKS_PER_HALF;
    // whole frame of each chip at four ticks per pixel
    localparam int FRAME_R8   = 4 * (int'(RASTER_X_MAX[0]) + 1) * (int'(RASTER_Y_MAX[0]) + 1);
    localparam int FRAME_R56A = 4 * (int'(RASTER_X_MAX[1]) + 1) * (int'(RASTER_Y_MAX[1]) + 1);
    localparam int FRAME_6569 = 4 * (int'(RASTER_X_MAX[2]) + 1) * (int'(RASTER_Y_MAX[2]) + 1);
    // the irq and badline runs each fit in a 6569 frame
    localparam int TIMEOUT_CYCLES = (FRAME_R8 + FRAME_R56A + 3 * FRAME_6569) * 5 / 4;

    // badline rules
    localparam int BAD_FIRST = 48;
    localparam int BAD_LAST  = 247;
    localparam int WIN_FIRST = 12;
    localparam int WIN_LAST  = 54;

    logic       clk_dot4x;
    logic       rst;
    chip_e      chip;
    logic [5:0] adi;
    logic [7:0] dbi;
    logic       ce;
    logic       rw;
    logic [7:0] dbo;
    logic       irq;
    logic       ba;
    logic       aec;
    logic       clk_phi;
    logic       write_db;

    // n counts ticks since reset release
    int     n;
    int     x_len;
    int     y_len;
    int     den;
    int     ysc;
    int     erst;
    int     rd_line;
    int     den_on;
    int     cycles;
    integer seed;

    vic_core vic_core_i (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip_i         (chip),
        .adi_i          (adi),
        .dbi_i          (dbi),
        .ce_i           (ce),
        .rw_i           (rw),
        .dbo_o          (dbo),
        .irq_o          (irq),
        .ba_o           (ba),
        .aec_o          (aec),
        .clk_phi_o      (clk_phi),
        .vic_write_db_o (write_db)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #4 clk_dot4x = ~clk_dot4x;
    end

    // hard stop if something never finishes
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk_dot4x);
            cycles = cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("run timed out after %0d cycles", cycles);
                $display("SOME TESTS FAILED");
                $fatal(1, "simulation timed out");
            end
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic int phi_of(input int t);
        return ((t % PHI_TICKS) >= TICKS_PER_HALF) ? 1 : 0;
    endfunction

    function automatic int line_of(input int t);
        return ((t / 4) / x_len) % y_len;
    endfunction

    // eight pixels per phi cycle
    function automatic int cycle_of(input int t);
        return ((t / 4) % x_len) / 8;
    endfunction

    function automatic int is_badline(input int l);
        return (l >= BAD_FIRST && l <= BAD_LAST && (l % 8) == ysc) ? 1 : 0;
    endfunction

    // line msb at bit 7 and den at bit 4 over yscroll
    function automatic int exp_ctrl1();
        return (((rd_line >> 8) & 1) << 7) | (den << 4) | ysc;
    endfunction

    function automatic int rand_below(input int limit);
        int r;
        r = $random(seed);
        r = r & 32'h7FFF_FFFF;
        return r % limit;
    endfunction

    // ------------------------------
    // checks and bus tasks
    // ------------------------------

    task automatic stop_on_error(input string what);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error("value mismatch");
        end
    endtask

    // one tick with outputs sampled 1 ns after the edge
    task automatic tick();
        @(posedge clk_dot4x);
        #1;
        n = n + 1;
        check_eq("clk_phi_o", int'(clk_phi), phi_of(n));
        check_eq("vic_write_db_o", int'(write_db), int'(rw && !ce));
        // no dma possible until den was set
        if (den_on == 0) begin
            check_eq("ba_o", int'(ba), 1);
            check_eq("aec_o", int'(aec), phi_of(n));
        end
    endtask

    task automatic apply_reset(input chip_e c);
        @(posedge clk_dot4x);
        #1;
        rst  = 1'b1;
        chip = c;
        ce   = 1'b1;
        rw   = 1'b1;
        repeat (4) @(posedge clk_dot4x);
        #1;
        rst    = 1'b0;
        n      = 0;
        den    = 0;
        ysc    = 0;
        erst   = 0;
        den_on = 0;
        x_len  = int'(RASTER_X_MAX[c]) + 1;
        y_len  = int'(RASTER_Y_MAX[c]) + 1;
        // idle outputs straight out of reset
        check_eq("irq_o", int'(irq), 0);
        check_eq("ba_o", int'(ba), 1);
        check_eq("aec_o", int'(aec), 0);
        check_eq("dbo_o", int'(dbo), 0);
    endtask

    // ce held low over one whole phi cycle that starts at a low phase
    task automatic cpu_write(input int addr, input int data);
        while ((n % PHI_TICKS) != 0) begin
            tick();
        end
        adi = 6'(addr);
        dbi = 8'(data);
        ce  = 1'b0;
        rw  = 1'b0;
        repeat (PHI_TICKS) tick();
        ce = 1'b1;
        rw = 1'b1;
    endtask

    // read data registers the line seen on the drive tick
    task automatic cpu_read(input int addr, output int data);
        adi     = 6'(addr);
        ce      = 1'b0;
        rw      = 1'b1;
        rd_line = line_of(n);
        tick();
        data = int'(dbo);
        ce   = 1'b1;
    endtask

    // ------------------------------
    // test runs
    // ------------------------------

    // register readback over a frame plus one line across the wrap
    task automatic run_chip(input chip_e c);
        int d;
        int a;
        int got;
        apply_reset(c);
        while (n < 4 * x_len * (y_len + 1)) begin
            case (rand_below(6))
                0: begin
                    // den bit kept clear
                    d = rand_below(256) & 'hEF;
                    cpu_write(int'(REG_CTRL1), d);
                    ysc = d & 7;
                end
                1: begin
                    d = rand_below(256);
                    cpu_write(int'(REG_IRQ_EN), d);
                    erst = d & 1;
                end
                2: begin
                    cpu_read(int'(REG_CTRL1), got);
                    check_eq("dbo_o", got, exp_ctrl1());
                end
                3: begin
                    cpu_read(int'(REG_IRQ_EN), got);
                    check_eq("dbo_o", got, 'hFE | erst);
                end
                4: begin
                    a = rand_below(64);
                    while (a == 'h11 || a == 'h12 || a == 'h19 || a == 'h1A) begin
                        a = rand_below(64);
                    end
                    cpu_read(a, got);
                    check_eq("dbo_o", got, 'hFF);
                end
                default: begin
                    cpu_read(int'(REG_RASTER), got);
                    check_eq("dbo_o", got, rd_line & 'hFF);
                end
            endcase
            repeat (rand_below(4000)) tick();
        end
        // reads past the end of the frame see the wrapped line
        cpu_read(int'(REG_RASTER), got);
        check_eq("dbo_o", got, rd_line & 'hFF);
        cpu_read(int'(REG_CTRL1), got);
        check_eq("dbo_o", got, exp_ctrl1());
    endtask

    task automatic run_irq();
        int cmp;
        int cmp2;
        int l;
        int got;
        apply_reset(CHIP_6569);
        cmp = 2 + rand_below(299);
        cpu_write(int'(REG_RASTER), cmp & 'hFF);
        cpu_write(int'(REG_CTRL1), (cmp >> 1) & 'h80);
        // compare was 0 at reset, so line 0 already set the latch
        cpu_write(int'(REG_IRQ_LATCH), 1);
        cpu_write(int'(REG_IRQ_EN), 1);
        erst = 1;
        while (!irq) begin
            tick();
        end
        assert (line_of(n) == cmp) else begin
            $display("irq_o rose on line %0d but the compare line is %0d", line_of(n), cmp);
            stop_on_error("irq on wrong line");
        end
        // held until acknowledged
        while (line_of(n) != cmp + 2) begin
            tick();
            check_eq("irq_o", int'(irq), 1);
        end
        cpu_write(int'(REG_IRQ_LATCH), 1);
        l = line_of(n);
        while (line_of(n) == l) begin
            check_eq("irq_o", int'(irq), 0);
            tick();
        end
        cpu_read(int'(REG_IRQ_LATCH), got);
        check_eq("dbo_o", got, 'h7E);
        // latch still fires with the enable off
        cpu_write(int'(REG_IRQ_EN), 0);
        erst = 0;
        cmp2 = line_of(n) + 2;
        cpu_write(int'(REG_RASTER), cmp2 & 'hFF);
        cpu_write(int'(REG_CTRL1), (cmp2 >> 1) & 'h80);
        while (line_of(n) != cmp2 + 1) begin
            tick();
            check_eq("irq_o", int'(irq), 0);
        end
        cpu_read(int'(REG_IRQ_LATCH), got);
        check_eq("dbo_o", got, 'h7F);
    endtask

    task automatic run_badline();
        int got;
        int pl;
        int pc;
        int seen_ba;
        int seen_aec;
        apply_reset(CHIP_6569);
        ysc    = rand_below(8);
        den    = 1;
        den_on = 1;
        cpu_write(int'(REG_CTRL1), 'h10 | ysc);
        cpu_read(int'(REG_CTRL1), got);
        check_eq("dbo_o", got, exp_ctrl1());
        seen_ba  = 0;
        seen_aec = 0;
        while (line_of(n) != BAD_LAST + 3) begin
            tick();
            // ba is registered, so it reflects the previous tick
            pl = line_of(n - 1);
            pc = cycle_of(n - 1);
            if (!ba) begin
                assert (is_badline(pl) == 1 && pc >= WIN_FIRST && pc <= WIN_LAST) else begin
                    $display("ba_o low on line %0d cycle %0d outside a badline window", pl, pc);
                    stop_on_error("unexpected ba_o low");
                end
                seen_ba = 1;
            end
            if (clk_phi && !aec) begin
                seen_aec = 1;
            end
            // end of a line
            if (line_of(n) != pl) begin
                if (is_badline(pl) == 1) begin
                    assert (seen_ba == 1 && seen_aec == 1) else begin
                        $display("badline %0d passed without ba_o low or aec_o held low", pl);
                        stop_on_error("missing character dma");
                    end
                end
                seen_ba  = 0;
                seen_aec = 0;
            end
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        rst     = 1'b1;
        chip    = CHIP_6567R8;
        adi     = '0;
        dbi     = '0;
        ce      = 1'b1;
        rw      = 1'b1;
        seed    = 54;
        n       = 0;
        rd_line = 0;
        den_on  = 0;
        run_chip(CHIP_6567R8);
        run_chip(CHIP_6567R56A);
        run_chip(CHIP_6569);
        run_irq();
        run_badline();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
src/vic_pkg.sv
src/phi_phase_gen.sv
src/raster_counter.sv
src/badline_arbiter.sv
src/vic_regs.sv
src/vic_core.sv
verif/tb_vic_core.sv
